// File: project.f
rtl/ddcpu_pkg.sv
rtl/run_control.sv
rtl/packet_loader.sv
rtl/packet_queue.sv
rtl/worker.sv
rtl/result_join.sv
rtl/dispatcher.sv
rtl/matching_memory.sv
rtl/ddcpu_top.sv
dv/tb_ddcpu.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_ddcpu -f project.f -o tb_ddcpu \
   && ./obj_dir/tb_ddcpu \
   || exit 1

// File: dv/tb_ddcpu.sv
`timescale 1ns/10ps

module tb_ddcpu
   import ddcpu_pkg::*;
;

   localparam int RUNS    = 10;
   localparam int TIMEOUT = 2000;

   logic        CLK;
   logic        RST         = 1'b1;
   logic        i_start     = 1'b0;
   start_args_t i_args      = '0;
   addr_t       i_opaddr    = '0;
   logic        i_mem_valid = 1'b0;
   instr_t      i_mem_data  = '0;
   logic        o_stop, o_done, o_mem_req;
   value_t      o_result;
   addr_t       o_mem_addr;

   instr_t prog [64];
   addr_t  mem_addr    = '0;
   logic [2:0] mem_wait = '0;
   int     starts_issued = 0;
   int     dones_seen    = 0;
   value_t exp_result    = '0;
   string  test_name     = "reset";

   ddcpu_top #(.WORKER_NUM(3), .QUEUE_DEPTH(4)) UUT (
      .CLK(CLK), .RST(RST), .i_start(i_start), .i_args(i_args), .i_opaddr(i_opaddr),
      .i_mem_valid(i_mem_valid), .i_mem_data(i_mem_data), .o_stop(o_stop),
      .o_done(o_done), .o_result(o_result), .o_mem_req(o_mem_req), .o_mem_addr(o_mem_addr)
   );

   initial begin
      CLK = 1'b0;
      forever #50 CLK = ~CLK;
   end

   // opcode of node k in run r
   function automatic opcode_e op_for(input int r, input int k);
      return opcode_e'(3'((r + k) % 5));
   endfunction

   function automatic value_t apply_op(input opcode_e op, input value_t x, input value_t y);
      case (op)
         OP_ADD:  return x + y;
         OP_SUB:  return x - y;
         OP_AND:  return x & y;
         OP_OR:   return x | y;
         default: return x ^ y;
      endcase
   endfunction

   // program memory answering after 1 to 4 cycles
   always @(posedge CLK) begin
      int delay;
      if (RST) begin
         i_mem_valid <= 1'b0;
         mem_wait    <= 3'd0;
      end else begin
         i_mem_valid <= 1'b0;
         if (o_mem_req) begin
            delay = $urandom_range(1, 4);
            if (delay == 1) begin
               i_mem_valid <= 1'b1;
               i_mem_data  <= prog[o_mem_addr[5:0]];
            end else begin
               mem_wait <= 3'(delay - 1);
               mem_addr <= o_mem_addr;
            end
         end else if (mem_wait == 3'd1) begin
            i_mem_valid <= 1'b1;
            i_mem_data  <= prog[mem_addr[5:0]];
            mem_wait    <= 3'd0;
         end else if (mem_wait != 3'd0) begin
            mem_wait <= mem_wait - 3'd1;
         end
      end
   end

   always @(posedge CLK) begin
      if (o_done) begin
         dones_seen <= dones_seen + 1;
      end
   end

   a_reset_idle: assert property (@(posedge CLK) disable iff (RST)
      starts_issued == 0 |-> o_stop && !o_done && !o_mem_req)
      else begin
         $display("outputs active before the first start");
         $display("=== FAIL ===");
         $fatal(1, "reset state violated");
      end

   a_result: assert property (@(posedge CLK) disable iff (RST)
      o_done |-> o_result == exp_result)
      else begin
         $display("Error %s: expected %h, actual %h", test_name, exp_result, o_result);
         $display("=== FAIL ===");
         $fatal(1, "wrong result");
      end

   a_stop_after_done: assert property (@(posedge CLK) disable iff (RST)
      o_done |=> o_stop)
      else begin
         $display("o_stop not high the cycle after o_done in %s", test_name);
         $display("=== FAIL ===");
         $fatal(1, "stop flag late");
      end

   a_addr_range: assert property (@(posedge CLK) disable iff (RST)
      o_mem_req |-> (o_mem_addr - i_opaddr) <= 32'd2)
      else begin
         $display("Error %s: expected address %h to %h, actual %h",
                  test_name, i_opaddr, i_opaddr + 32'd2, o_mem_addr);
         $display("=== FAIL ===");
         $fatal(1, "bad fetch address");
      end

   // one done per accepted start
   a_single_done: assert property (@(posedge CLK) disable iff (RST)
      o_done |-> dones_seen < starts_issued)
      else begin
         $display("extra o_done without a new start in %s", test_name);
         $display("=== FAIL ===");
         $fatal(1, "unexpected done");
      end

   initial begin
      int          n;
      start_args_t args;
      value_t      expv;
      void'($urandom(32'h06e903c9));
      for (int i = 0; i < 64; i++) begin
         prog[i] = '0;
      end
      // nodes 0 and 1 feed node 2 which feeds the end node
      for (int r = 0; r < RUNS; r++) begin
         prog[3*r]   = '{unused: '0, opcode: op_for(r, 0), dest: node_t'(2), slot: 1'b0};
         prog[3*r+1] = '{unused: '0, opcode: op_for(r, 1), dest: node_t'(2), slot: 1'b1};
         prog[3*r+2] = '{unused: '0, opcode: op_for(r, 2), dest: END_NODE, slot: 1'b0};
      end
      repeat (16) @(posedge CLK);
      RST <= 1'b0;
      repeat (6) @(posedge CLK);
      for (int r = 0; r < RUNS; r++) begin
         args.a0 = $urandom();
         args.a1 = $urandom();
         args.a2 = $urandom();
         args.a3 = $urandom();
         expv = apply_op(op_for(r, 2), apply_op(op_for(r, 0), args.a0, args.a1),
                         apply_op(op_for(r, 1), args.a2, args.a3));
         test_name = $sformatf("run %0d", r);
         @(posedge CLK);
         i_args        <= args;
         i_opaddr      <= addr_t'(3 * r);
         i_start       <= 1'b1;
         exp_result    <= expv;
         starts_issued <= starts_issued + 1;
         @(posedge CLK);
         i_start <= 1'b0;
         // operands were captured at start
         i_args  <= ~args;
         if (r % 2 == 1) begin
            n = 0;
            while (o_stop && n < TIMEOUT) begin
               @(negedge CLK);
               n++;
            end
            if (o_stop) begin
               $display("=== FAIL ===");
               $fatal(1, "timeout waiting for o_stop to fall in %s", test_name);
            end
            @(posedge CLK);
            i_start <= 1'b1;
            @(posedge CLK);
            i_start <= 1'b0;
         end
         n = 0;
         while (dones_seen == r && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
         end
         if (dones_seen == r) begin
            $display("=== FAIL ===");
            $fatal(1, "timeout waiting for o_done in %s", test_name);
         end
         n = 0;
         while (!o_stop && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
         end
         if (!o_stop) begin
            $display("=== FAIL ===");
            $fatal(1, "timeout waiting for o_stop to rise in %s", test_name);
         end
      end
      repeat (10) @(posedge CLK);
      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: rtl/ddcpu_top.sv
`timescale 1ns/10ps

module ddcpu_top
   import ddcpu_pkg::*;
#(
   parameter int WORKER_NUM  = 3,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic        CLK,
   input  logic        RST,
   input  logic        i_start,
   input  start_args_t i_args,
   input  addr_t       i_opaddr,
   input  logic        i_mem_valid,
   input  instr_t      i_mem_data,
   output logic        o_stop,
   output logic        o_done,
   output value_t      o_result,
   output logic        o_mem_req,
   output addr_t       o_mem_addr
);

   localparam int NODE_COUNT = 2 ** NODE_BITS;

   logic       end_pulse;
   logic       st_valid, st_ready;
   pair_req_t  st_req;
   logic       mt_valid, mt_ready;
   pair_req_t  mt_req;
   logic       pl_valid, pl_ready;
   op_packet_t pl_pkt;

   logic [WORKER_NUM-1:0]   wk_valid, wk_ready;
   op_packet_t              wk_pkt;
   logic [WORKER_NUM-1:0]   res_valid, res_ready;
   token_t [WORKER_NUM-1:0] res_token;

   logic   jn_valid, jn_ready;
   token_t jn_token;
   logic   mm_valid, mm_ready;
   token_t mm_token;

   run_control u_run_control (
      .CLK         (CLK),
      .RST         (RST),
      .i_start     (i_start),
      .i_args      (i_args),
      .i_end       (end_pulse),
      .i_req_ready (st_ready),
      .o_stop      (o_stop),
      .o_req_valid (st_valid),
      .o_req       (st_req)
   );

   packet_loader u_packet_loader (
      .CLK           (CLK),
      .RST           (RST),
      .i_opaddr      (i_opaddr),
      .i_start_valid (st_valid),
      .i_start_req   (st_req),
      .i_match_valid (mt_valid),
      .i_match_req   (mt_req),
      .i_mem_valid   (i_mem_valid),
      .i_mem_data    (i_mem_data),
      .i_pkt_ready   (pl_ready),
      .o_start_ready (st_ready),
      .o_match_ready (mt_ready),
      .o_mem_req     (o_mem_req),
      .o_mem_addr    (o_mem_addr),
      .o_pkt_valid   (pl_valid),
      .o_pkt         (pl_pkt)
   );

   packet_queue #(
      .WORKER_NUM  (WORKER_NUM),
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_packet_queue (
      .CLK        (CLK),
      .RST        (RST),
      .i_valid    (pl_valid),
      .i_pkt      (pl_pkt),
      .i_wk_ready (wk_ready),
      .o_ready    (pl_ready),
      .o_wk_valid (wk_valid),
      .o_wk_pkt   (wk_pkt)
   );

   for (genvar g = 0; g < WORKER_NUM; g++) begin : g_worker
      worker u_worker (
         .CLK     (CLK),
         .RST     (RST),
         .i_valid (wk_valid[g]),
         .i_pkt   (wk_pkt),
         .i_ready (res_ready[g]),
         .o_ready (wk_ready[g]),
         .o_valid (res_valid[g]),
         .o_token (res_token[g])
      );
   end

   result_join #(
      .WORKER_NUM (WORKER_NUM)
   ) u_result_join (
      .CLK     (CLK),
      .RST     (RST),
      .i_valid (res_valid),
      .i_token (res_token),
      .i_ready (jn_ready),
      .o_ready (res_ready),
      .o_valid (jn_valid),
      .o_token (jn_token)
   );

   dispatcher u_dispatcher (
      .CLK        (CLK),
      .RST        (RST),
      .i_valid    (jn_valid),
      .i_token    (jn_token),
      .i_mm_ready (mm_ready),
      .o_ready    (jn_ready),
      .o_mm_valid (mm_valid),
      .o_mm_token (mm_token),
      .o_end      (end_pulse),
      .o_done     (o_done),
      .o_result   (o_result)
   );

   matching_memory #(
      .NODE_COUNT (NODE_COUNT)
   ) u_matching_memory (
      .CLK     (CLK),
      .RST     (RST),
      .i_valid (mm_valid),
      .i_token (mm_token),
      .i_ready (mt_ready),
      .o_ready (mm_ready),
      .o_valid (mt_valid),
      .o_req   (mt_req)
   );

endmodule

// File: rtl/matching_memory.sv
`timescale 1ns/10ps

module matching_memory
   import ddcpu_pkg::*;
#(
   parameter int NODE_COUNT = 64
) (
   input  logic      CLK,
   input  logic      RST,
   input  logic      i_valid,
   input  token_t    i_token,
   input  logic      i_ready,
   output logic      o_ready,
   output logic      o_valid,
   output pair_req_t o_req
);

   logic [NODE_COUNT-1:0] present;
   logic [NODE_COUNT-1:0] present_slot;
   value_t                store [NODE_COUNT];
   logic                  acc, hit;

   assign o_ready = !o_valid || i_ready;
   assign acc     = i_valid && o_ready;
   assign hit     = present[i_token.node];

   always_ff @(posedge CLK) begin
      if (RST) begin
         present <= '0;
         o_valid <= 1'b0;
      end else begin
         if (acc) begin
            present[i_token.node] <= !hit;
         end
         if (acc && hit) begin
            o_valid <= 1'b1;
         end else if (i_ready) begin
            o_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (acc && !hit) begin
         store[i_token.node]        <= i_token.value;
         present_slot[i_token.node] <= i_token.slot;
      end
      // slot 0 is operand a
      if (acc && hit) begin
         o_req.node <= i_token.node;
         if (i_token.slot) begin
            o_req.a <= store[i_token.node];
            o_req.b <= i_token.value;
         end else begin
            o_req.a <= i_token.value;
            o_req.b <= store[i_token.node];
         end
      end
   end

   // each node gets exactly one token per slot
   a_slot_clash: assert property (@(posedge CLK) disable iff (RST)
      acc && hit |-> present_slot[i_token.node] != i_token.slot);

endmodule

// File: rtl/dispatcher.sv
`timescale 1ns/10ps

module dispatcher
   import ddcpu_pkg::*;
(
   input  logic   CLK,
   input  logic   RST,
   input  logic   i_valid,
   input  token_t i_token,
   input  logic   i_mm_ready,
   output logic   o_ready,
   output logic   o_mm_valid,
   output token_t o_mm_token,
   output logic   o_end,
   output logic   o_done,
   output value_t o_result
);

   logic   hold_v;
   token_t hold_q;
   logic   acc, is_end;

   assign o_ready = !hold_v || i_mm_ready;
   assign acc     = i_valid && o_ready;
   assign is_end  = (i_token.node == END_NODE);

   always_ff @(posedge CLK) begin
      if (RST) begin
         hold_v   <= 1'b0;
         o_end    <= 1'b0;
         o_result <= '0;
      end else begin
         o_end <= acc && is_end;
         if (acc && is_end) begin
            o_result <= i_token.value;
         end
         if (acc && !is_end) begin
            hold_v <= 1'b1;
         end else if (i_mm_ready) begin
            hold_v <= 1'b0;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (acc && !is_end) begin
         hold_q <= i_token;
      end
   end

   assign o_mm_valid = hold_v;
   assign o_mm_token = hold_q;
   assign o_done     = o_end;

endmodule

// File: rtl/result_join.sv
`timescale 1ns/10ps

module result_join
   import ddcpu_pkg::*;
#(
   parameter int WORKER_NUM = 3
) (
   input  logic                    CLK,
   input  logic                    RST,
   input  logic [WORKER_NUM-1:0]   i_valid,
   input  token_t [WORKER_NUM-1:0] i_token,
   input  logic                    i_ready,
   output logic [WORKER_NUM-1:0]   o_ready,
   output logic                    o_valid,
   output token_t                  o_token
);

   localparam int PW = (WORKER_NUM > 1) ? $clog2(WORKER_NUM) : 1;

   logic [PW-1:0] ptr;
   logic [PW-1:0] sel;
   logic          found;

   // first valid at or after the pointer
   always_comb begin
      int idx;
      found = 1'b0;
      sel   = '0;
      for (int k = 0; k < WORKER_NUM; k++) begin
         idx = (int'(ptr) + k) % WORKER_NUM;
         if (!found && i_valid[idx]) begin
            found = 1'b1;
            sel   = PW'(idx);
         end
      end
   end

   always_comb begin
      for (int i = 0; i < WORKER_NUM; i++) begin
         o_ready[i] = found && i_ready && (sel == PW'(i));
      end
   end

   assign o_valid = found;
   assign o_token = i_token[sel];

   always_ff @(posedge CLK) begin
      if (RST) begin
         ptr <= '0;
      end else if (found && i_ready) begin
         ptr <= (sel == PW'(WORKER_NUM - 1)) ? '0 : sel + 1'b1;
      end
   end

endmodule

// File: rtl/worker.sv
`timescale 1ns/10ps

module worker
   import ddcpu_pkg::*;
(
   input  logic       CLK,
   input  logic       RST,
   input  logic       i_valid,
   input  op_packet_t i_pkt,
   input  logic       i_ready,
   output logic       o_ready,
   output logic       o_valid,
   output token_t     o_token
);

   logic   busy;
   token_t tok_q;
   value_t alu;

   always_comb begin
      case (i_pkt.opcode)
         OP_ADD:  alu = i_pkt.a + i_pkt.b;
         OP_SUB:  alu = i_pkt.a - i_pkt.b;
         OP_AND:  alu = i_pkt.a & i_pkt.b;
         OP_OR:   alu = i_pkt.a | i_pkt.b;
         OP_XOR:  alu = i_pkt.a ^ i_pkt.b;
         default: alu = '0;
      endcase
   end

   always_ff @(posedge CLK) begin
      if (RST) begin
         busy <= 1'b0;
      end else if (i_valid && o_ready) begin
         busy <= 1'b1;
      end else if (i_ready) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge CLK) begin
      if (i_valid && o_ready) begin
         tok_q <= '{node: i_pkt.dest, slot: i_pkt.slot, value: alu};
      end
   end

   assign o_ready = !busy;
   assign o_valid = busy;
   assign o_token = tok_q;

endmodule

// File: rtl/packet_queue.sv
`timescale 1ns/10ps

module packet_queue
   import ddcpu_pkg::*;
#(
   parameter int WORKER_NUM  = 3,
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                  CLK,
   input  logic                  RST,
   input  logic                  i_valid,
   input  op_packet_t            i_pkt,
   input  logic [WORKER_NUM-1:0] i_wk_ready,
   output logic                  o_ready,
   output logic [WORKER_NUM-1:0] o_wk_valid,
   output op_packet_t            o_wk_pkt
);

   localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
   localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

   op_packet_t       mem [QUEUE_DEPTH];
   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic [CNT_W-1:0] count;
   logic             empty, wr, rd, taken;

   assign empty   = (count == '0);
   assign o_ready = (count != CNT_W'(QUEUE_DEPTH));
   assign wr      = i_valid && o_ready;
   assign rd      = !empty && (|i_wk_ready);

   assign o_wk_pkt = mem[rd_ptr];

   // offer the head to the lowest ready worker
   always_comb begin
      taken = 1'b0;
      for (int i = 0; i < WORKER_NUM; i++) begin
         o_wk_valid[i] = !empty && i_wk_ready[i] && !taken;
         if (i_wk_ready[i]) begin
            taken = 1'b1;
         end
      end
   end

   always_ff @(posedge CLK) begin
      if (RST) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr) begin
            wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (rd) begin
            rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (wr) begin
         mem[wr_ptr] <= i_pkt;
      end
   end

   // a packet refused while full is kept for the next try
   a_full_hold: assert property (@(posedge CLK) disable iff (RST)
      i_valid && !o_ready |=> i_valid && $stable(i_pkt));

endmodule

// File: rtl/packet_loader.sv
`timescale 1ns/10ps

module packet_loader
   import ddcpu_pkg::*;
(
   input  logic       CLK,
   input  logic       RST,
   input  addr_t      i_opaddr,
   input  logic       i_start_valid,
   input  pair_req_t  i_start_req,
   input  logic       i_match_valid,
   input  pair_req_t  i_match_req,
   input  logic       i_mem_valid,
   input  instr_t     i_mem_data,
   input  logic       i_pkt_ready,
   output logic       o_start_ready,
   output logic       o_match_ready,
   output logic       o_mem_req,
   output addr_t      o_mem_addr,
   output logic       o_pkt_valid,
   output op_packet_t o_pkt
);

   pl_state_e state;
   pair_req_t req_q;
   pair_req_t sel_req;
   logic      can_take;
   logic      take;

   assign can_take      = (state == PL_IDLE) && !o_pkt_valid;
   assign o_match_ready = can_take;
   // match channel wins
   assign o_start_ready = can_take && !i_match_valid;
   assign sel_req       = i_match_valid ? i_match_req : i_start_req;
   assign take          = (i_match_valid && o_match_ready) ||
                          (i_start_valid && o_start_ready);

   always_ff @(posedge CLK) begin
      if (RST) begin
         state       <= PL_IDLE;
         o_mem_req   <= 1'b0;
         o_pkt_valid <= 1'b0;
      end else begin
         o_mem_req <= 1'b0;
         if (o_pkt_valid && i_pkt_ready) begin
            o_pkt_valid <= 1'b0;
         end
         case (state)
            PL_IDLE: begin
               if (take) begin
                  o_mem_req <= 1'b1;
                  state     <= PL_FETCH;
               end
            end
            PL_FETCH: begin
               if (i_mem_valid) begin
                  o_pkt_valid <= 1'b1;
                  state       <= PL_IDLE;
               end
            end
            default: state <= PL_IDLE;
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (state == PL_IDLE && take) begin
         req_q      <= sel_req;
         o_mem_addr <= i_opaddr + addr_t'(sel_req.node);
      end
      if (state == PL_FETCH && i_mem_valid) begin
         o_pkt <= '{opcode: i_mem_data.opcode, dest: i_mem_data.dest,
                    slot: i_mem_data.slot, a: req_q.a, b: req_q.b};
      end
   end

   // memory answers only the fetch in flight
   a_mem_in_fetch: assert property (@(posedge CLK) disable iff (RST)
      i_mem_valid |-> state == PL_FETCH);

endmodule

// File: rtl/run_control.sv
`timescale 1ns/10ps

module run_control
   import ddcpu_pkg::*;
(
   input  logic        CLK,
   input  logic        RST,
   input  logic        i_start,
   input  start_args_t i_args,
   input  logic        i_end,
   input  logic        i_req_ready,
   output logic        o_stop,
   output logic        o_req_valid,
   output pair_req_t   o_req
);

   // start pairs still to send
   logic [1:0]  pend;
   start_args_t args_q;

   always_ff @(posedge CLK) begin
      if (RST) begin
         o_stop <= 1'b1;
         pend   <= 2'd0;
      end else if (i_end) begin
         o_stop <= 1'b1;
      end else if (i_start && o_stop) begin
         o_stop <= 1'b0;
         pend   <= 2'd2;
      end else if (o_req_valid && i_req_ready) begin
         pend <= pend - 2'd1;
      end
   end

   always_ff @(posedge CLK) begin
      if (i_start && o_stop) begin
         args_q <= i_args;
      end
   end

   assign o_req_valid = (pend != 2'd0);

   // node 0 goes first
   always_comb begin
      if (pend == 2'd2) begin
         o_req = '{node: node_t'(0), a: args_q.a0, b: args_q.a1};
      end else begin
         o_req = '{node: node_t'(1), a: args_q.a2, b: args_q.a3};
      end
   end

   // an end token only exists inside a run
   a_end_while_running: assert property (@(posedge CLK) disable iff (RST)
      i_end |-> !o_stop);

endmodule

// File: rtl/ddcpu_pkg.sv
package ddcpu_pkg;

   localparam int NODE_BITS = 6;

   typedef logic [31:0]          value_t;
   typedef logic [NODE_BITS-1:0] node_t;
   typedef logic [31:0]          addr_t;

   // results sent here finish the run
   localparam node_t END_NODE = '1;

   typedef enum logic [2:0] {
      OP_ADD,
      OP_SUB,
      OP_AND,
      OP_OR,
      OP_XOR
   } opcode_e;

   typedef struct packed {
      logic [21:0] unused;
      opcode_e     opcode;
      node_t       dest;
      logic        slot;
   } instr_t;

   typedef struct packed {
      node_t  node;
      logic   slot;
      value_t value;
   } token_t;

   typedef struct packed {
      node_t  node;
      value_t a;
      value_t b;
   } pair_req_t;

   typedef struct packed {
      opcode_e opcode;
      node_t   dest;
      logic    slot;
      value_t  a;
      value_t  b;
   } op_packet_t;

   typedef struct packed {
      value_t a0;
      value_t a1;
      value_t a2;
      value_t a3;
   } start_args_t;

   typedef enum logic {
      PL_IDLE,
      PL_FETCH
   } pl_state_e;

endpackage
